//--- verilog/rtg_pkg.sv
////////////////////////////////////////
// Shared widths, sizes and types for the RTG display path
// Imported by every RTG block and by the testbench
////////////////////////////////////////

package rtg_pkg;

	////////////////////////////////////////
	// Sizes

	localparam int WORD_W      = 16;  // Fetched pixel word
	localparam int ADDR_W      = 25;  // Word address into video memory
	localparam int BURST_WORDS = 8;   // Words per memory burst
	localparam int FIFO_DEPTH  = 32;  // Stream FIFO capacity in words
	localparam int PIXW_W      = 4;   // Clocks per fetch, minus one
	localparam int VBEND_W     = 7;   // Lines of vblank extension

	// Derived pointer widths
	localparam int FIFO_AW  = $clog2(FIFO_DEPTH);
	localparam int BURST_AW = $clog2(BURST_WORDS);

	////////////////////////////////////////
	// Types

	// 24-bit colour, red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef logic [WORD_W-1:0] rtg_word_t;  // One word from the stream
	typedef logic [7:0]        clut_idx_t;  // Palette index in 8-bit mode
	typedef logic [ADDR_W-1:0] rtg_addr_t;  // Word address

endpackage

//--- verilog/rtg_beat_if.sv
////////////////////////////////////////
// Pixel beat from the timing block
// Read by the stream fetcher and the mixer
////////////////////////////////////////

`timescale 1ns/1ps

interface rtg_beat_if;

	logic pix_stb;     // Pop next word
	logic idx_sel;     // Low = high byte, high = low byte
	logic idx_stb;     // Rising edge of idx_sel
	logic blank_late;  // Blank, two clocks late
	logic restart;     // Vblank or RTG off

	modport timing (output pix_stb, idx_sel, idx_stb, blank_late, restart);

	// Fetcher only pops and restarts
	modport fetch (input pix_stb, restart);

	modport mixer (input pix_stb, idx_sel, idx_stb, blank_late);

endinterface

//--- verilog/rtg_pixel_timing.sv
////////////////////////////////////////
// RTG pixel timing: fetch counter, blanking and vblank extension
// Also makes the native pixel strobe for pass-through video
////////////////////////////////////////

`timescale 1ns/1ps

module rtg_pixel_timing
	import rtg_pkg::*;
(
	input  logic               CLK_114,
	input  logic               arst_n,
	input  logic               rtg_ena,
	input  logic               rtg_ext,      // One extra fetch past blank
	input  logic               scan_15khz,
	input  logic [PIXW_W-1:0]  pixel_width,  // Clocks per fetch - 1
	input  logic [VBEND_W-1:0] vb_end,       // Vblank extension in lines
	input  logic               hblank,
	input  logic               vblank,
	input  logic               hsync,
	rtg_beat_if.timing         beat,
	output logic               native_stb
);

	logic [PIXW_W-1:0]  pix_cnt;   // Fetch counter
	logic [VBEND_W-1:0] vb_cnt;    // Lines since vblank fell
	logic               rtg_vblank;
	logic               blank;
	logic               blank_d;
	logic               blank_d2;
	logic               hs_d;
	logic               idx_sel;
	logic               idx_sel_d;
	logic [2:0]         step;      // Native strobe step counter

	////////////////////////////////////////
	// Blanking

	assign blank = hblank | rtg_vblank;

	// Chipset vblank is too short for RTG, stretch it by vb_end lines
	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			hs_d       <= 1'b0;
			rtg_vblank <= 1'b1;
			vb_cnt     <= '0;
			blank_d    <= 1'b1;
			blank_d2   <= 1'b1;
		end else begin
			hs_d     <= hsync;
			blank_d  <= blank;
			blank_d2 <= blank_d;  // Lines up with mixer output
			if (vblank) begin
				rtg_vblank <= 1'b1;
				vb_cnt     <= '0;
			end else if (vb_cnt == vb_end) begin
				rtg_vblank <= 1'b0;
			end else if (hsync && !hs_d) begin
				vb_cnt <= vb_cnt + 1'b1;  // Count hsync rising edges
			end
		end
	end

	////////////////////////////////////////
	// Fetch counter

	// Fires on count match, or once more just after blank with rtg_ext
	assign beat.pix_stb = rtg_ena && (!blank || (!blank_d && rtg_ext))
		&& (pix_cnt == pixel_width);

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt   <= '0;
			idx_sel   <= 1'b0;
			idx_sel_d <= 1'b0;
		end else begin
			idx_sel_d <= idx_sel;
			if (pix_cnt == {1'b0, pixel_width[PIXW_W-1:1]})
				idx_sel <= 1'b1;  // Second byte at half the fetch period
			if (blank || beat.pix_stb) begin
				pix_cnt <= '0;
				idx_sel <= 1'b0;  // Back to the high byte
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	assign beat.idx_sel    = idx_sel;
	assign beat.idx_stb    = idx_sel && !idx_sel_d;
	assign beat.blank_late = blank_d2;
	assign beat.restart    = vblank || !rtg_ena;  // Raw vblank, not extended

	// Native strobe, every 8 clocks or every 4 at 15 kHz
	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n)
			step <= '0;
		else
			step <= scan_15khz ? {step[2:1], 1'b0} + 3'd2 : step + 3'd1;
	end

	assign native_stb = (step == 3'd0);

endmodule

//--- verilog/rtg_stream_fetch.sv
////////////////////////////////////////
// Word FIFO streaming the RTG frame from memory in bursts
// Refills whenever a burst fits and restarts at base_addr each vblank
////////////////////////////////////////

`timescale 1ns/1ps

module rtg_stream_fetch
	import rtg_pkg::*;
(
	input  logic      CLK_114,
	input  logic      arst_n,
	input  rtg_addr_t base_addr,
	rtg_beat_if.fetch beat,
	output logic      mem_req,   // Held until the last fill
	output rtg_addr_t mem_addr,
	input  logic      mem_fill,  // One pulse per word
	input  rtg_word_t mem_data,
	output rtg_word_t head       // Last popped word
);

	rtg_word_t           fifo_mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0]  wr_ptr;
	logic [FIFO_AW-1:0]  rd_ptr;
	logic [FIFO_AW:0]    count;     // Words stored
	logic [BURST_AW-1:0] fill_cnt;  // Fills in current burst
	logic                busy;      // Burst outstanding
	logic                discard;   // Burst belongs to the old frame
	logic                last_fill;
	logic                keep_fill;
	logic                can_req;
	logic                do_pop;

	assign last_fill = mem_fill && busy && (fill_cnt == BURST_AW'(BURST_WORDS - 1));
	assign keep_fill = mem_fill && busy && !discard && !beat.restart;
	assign can_req   = !busy && !beat.restart
		&& (count <= (FIFO_AW + 1)'(FIFO_DEPTH - BURST_WORDS));  // Room for a burst
	assign do_pop    = beat.pix_stb && (count != '0) && !beat.restart;

	////////////////////////////////////////
	// Burst requests

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			discard  <= 1'b0;
			fill_cnt <= '0;
			mem_req  <= 1'b0;
			mem_addr <= '0;
		end else begin
			if (mem_fill && busy)
				fill_cnt <= last_fill ? '0 : fill_cnt + 1'b1;
			if (last_fill) begin
				busy    <= 1'b0;
				discard <= 1'b0;
				mem_req <= 1'b0;
			end else if (can_req) begin
				busy    <= 1'b1;
				mem_req <= 1'b1;
			end
			if (beat.restart) begin
				mem_req  <= 1'b0;
				mem_addr <= base_addr;
				if (busy && !last_fill)
					discard <= 1'b1;  // Let the old burst drain
			end else if (last_fill && !discard) begin
				mem_addr <= mem_addr + rtg_addr_t'(BURST_WORDS);
			end
		end
	end

	////////////////////////////////////////
	// Pointers and level

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (beat.restart) begin
			wr_ptr <= '0;  // Flush
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (keep_fill)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({keep_fill, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage, empty pop leaves head as it was
	always_ff @(posedge CLK_114) begin
		if (keep_fill)
			fifo_mem[wr_ptr] <= mem_data;
		if (do_pop)
			head <= fifo_mem[rd_ptr];
	end

	// Memory must stop after BURST_WORDS fills
	a_burst_len: assert property (@(posedge CLK_114) disable iff (!arst_n)
		mem_fill |-> busy)
		else $error("mem_fill outside a requested burst");

	// Display ran ahead of the memory
	a_underrun: assert property (@(posedge CLK_114) disable iff (!arst_n)
		(beat.pix_stb && !beat.restart) |-> (count != '0))
		else $error("pixel pop from empty FIFO");

endmodule

//--- verilog/rtg_video_mixer.sv
////////////////////////////////////////
// Colour formatting, native/RTG select, OSD overlay and syncs
// Feeds the VGA pins with a strobe per new pixel
////////////////////////////////////////

`timescale 1ns/1ps

module rtg_video_mixer
	import rtg_pkg::*;
(
	input  logic      CLK_114,
	input  logic      arst_n,
	input  logic      rtg_ena,
	input  logic      rtg_16bit,    // 5-6-5, else 5-5-5
	input  logic      rtg_clut,     // 8-bit indexed
	rtg_beat_if.mixer beat,
	input  rtg_word_t head,
	input  logic      clut_wr,
	input  clut_idx_t clut_wr_idx,
	input  rgb_t      clut_wr_rgb,
	input  rgb_t      native_rgb,
	input  logic      native_stb,
	input  logic      hsync,
	input  logic      vsync,
	input  logic      csync,
	input  logic      hsync_pol,
	input  logic      vsync_pol,
	input  logic      osd_window,
	input  logic      osd_pixel,
	output rgb_t      vga_rgb,
	output logic      vga_hs,
	output logic      vga_vs,
	output logic      vga_cs,
	output logic      vga_pixel
);

	rgb_t      clut [256];  // Palette
	clut_idx_t idx;
	rgb_t      clut_rgb;
	rgb_t      direct_rgb;
	rgb_t      rtg_rgb;
	rgb_t      rgb_q;
	logic      pix_stb_d;
	logic      new_pix;
	logic      hs_q;
	logic      vs_q;
	logic      cs_q;

	always_ff @(posedge CLK_114) begin
		if (clut_wr)
			clut[clut_wr_idx] <= clut_wr_rgb;
	end

	////////////////////////////////////////
	// RTG colour

	assign idx      = beat.idx_sel ? head[7:0] : head[15:8];  // High byte first
	assign clut_rgb = clut[idx];

	// Top bits repeated into the low bits
	always_comb begin
		direct_rgb.b = {head[4:0], head[4:2]};
		if (rtg_16bit) begin
			direct_rgb.r = {head[15:11], head[15:13]};
			direct_rgb.g = {head[10:5], head[10:9]};
		end else begin
			direct_rgb.r = {head[14:10], head[14:12]};
			direct_rgb.g = {head[9:5], head[9:7]};
		end
	end

	assign rtg_rgb = rtg_clut ? clut_rgb : direct_rgb;

	// Second byte of a CLUT word counts as a pixel too
	assign new_pix = rtg_ena ? (pix_stb_d || (beat.idx_stb && rtg_clut)) : native_stb;

	////////////////////////////////////////
	// Output registers

	always_ff @(posedge CLK_114) begin
		rgb_q <= (rtg_ena && !beat.blank_late) ? rtg_rgb : native_rgb;
	end

	always_ff @(posedge CLK_114 or negedge arst_n) begin
		if (!arst_n) begin
			pix_stb_d <= 1'b0;
			vga_pixel <= 1'b0;
			hs_q      <= 1'b0;
			vs_q      <= 1'b0;
			cs_q      <= 1'b0;
		end else begin
			pix_stb_d <= beat.pix_stb;  // Head is valid one clock after pop
			vga_pixel <= new_pix;
			hs_q      <= hsync;
			vs_q      <= vsync;
			cs_q      <= csync;
		end
	end

	// OSD takes the top two bits, picture dimmed underneath
	always_comb begin
		vga_rgb = rgb_q;
		if (osd_window) begin
			vga_rgb.r = {osd_pixel ? 2'b11 : 2'b00, rgb_q.r[7:2]};
			vga_rgb.g = {osd_pixel ? 2'b11 : 2'b00, rgb_q.g[7:2]};
			vga_rgb.b = {osd_pixel ? 2'b11 : 2'b10, rgb_q.b[7:2]};  // Blue backdrop
		end
	end

	assign vga_hs = hs_q ^ hsync_pol;
	assign vga_vs = vs_q ^ vsync_pol;
	assign vga_cs = cs_q;

endmodule

//--- verilog/rtg_video_top.sv
////////////////////////////////////////
// RTG display path top level with native video pass-through
// Memory side is a plain request/fill port served from outside
////////////////////////////////////////

`timescale 1ns/1ps

module rtg_video_top
	import rtg_pkg::*;
(
	input  logic               CLK_114,
	input  logic               arst_n,
	// RTG control
	input  logic               rtg_ena,
	input  logic               rtg_ext,
	input  logic               rtg_16bit,
	input  logic               rtg_clut,
	input  logic               scan_15khz,
	input  logic [PIXW_W-1:0]  pixel_width,
	input  logic [VBEND_W-1:0] vb_end,
	input  rtg_addr_t          base_addr,
	input  logic               clut_wr,
	input  clut_idx_t          clut_wr_idx,
	input  rgb_t               clut_wr_rgb,
	// Native chipset video
	input  logic               hblank,
	input  logic               vblank,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               csync,
	input  logic               hsync_pol,
	input  logic               vsync_pol,
	input  logic [7:0]         native_r,
	input  logic [7:0]         native_g,
	input  logic [7:0]         native_b,
	input  logic               osd_window,
	input  logic               osd_pixel,
	// Memory
	output logic               mem_req,
	output rtg_addr_t          mem_addr,
	input  logic               mem_fill,
	input  rtg_word_t          mem_data,
	// VGA
	output logic [7:0]         vga_r,
	output logic [7:0]         vga_g,
	output logic [7:0]         vga_b,
	output logic               vga_hs,
	output logic               vga_vs,
	output logic               vga_cs,
	output logic               vga_pixel
);

	rtg_beat_if beat ();

	rtg_word_t head;        // Current stream word
	logic      native_stb;
	rgb_t      native_rgb;
	rgb_t      vga_rgb;

	assign native_rgb = {native_r, native_g, native_b};

	rtg_pixel_timing u_timing (
		.CLK_114(CLK_114), .arst_n(arst_n), .rtg_ena(rtg_ena), .rtg_ext(rtg_ext),
		.scan_15khz(scan_15khz), .pixel_width(pixel_width), .vb_end(vb_end),
		.hblank(hblank), .vblank(vblank), .hsync(hsync),
		.beat(beat.timing), .native_stb(native_stb)
	);

	rtg_stream_fetch u_fetch (
		.CLK_114(CLK_114), .arst_n(arst_n), .base_addr(base_addr), .beat(beat.fetch),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_fill(mem_fill),
		.mem_data(mem_data), .head(head)
	);

	rtg_video_mixer u_mixer (
		.CLK_114(CLK_114), .arst_n(arst_n), .rtg_ena(rtg_ena), .rtg_16bit(rtg_16bit),
		.rtg_clut(rtg_clut), .beat(beat.mixer), .head(head), .clut_wr(clut_wr),
		.clut_wr_idx(clut_wr_idx), .clut_wr_rgb(clut_wr_rgb),
		.native_rgb(native_rgb), .native_stb(native_stb),
		.hsync(hsync), .vsync(vsync), .csync(csync),
		.hsync_pol(hsync_pol), .vsync_pol(vsync_pol),
		.osd_window(osd_window), .osd_pixel(osd_pixel),
		.vga_rgb(vga_rgb), .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_cs(vga_cs),
		.vga_pixel(vga_pixel)
	);

	assign vga_r = vga_rgb.r;
	assign vga_g = vga_rgb.g;
	assign vga_b = vga_rgb.b;

endmodule

//--- tb/rtg_tb_tasks.svh
////////////////////////////////////////
// Directed tests and compare tasks, included into the testbench
////////////////////////////////////////

////////////////////////////////////////
// Compare tasks

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		abort_run("colour compare failed");
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
		abort_run("bit compare failed");
	end
endtask

task automatic check_addr(input string name, input rtg_addr_t got, input rtg_addr_t exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		abort_run("address compare failed");
	end
endtask

// Field of the given width moved to the top, its top bits repeated below
function automatic logic [7:0] widen(input logic [7:0] field, input int bits);
	logic [7:0] top;
	top = field << (8 - bits);
	return top | (top >> bits);
endfunction

function automatic rgb_t expand_565(input rtg_word_t w);
	rgb_t c;
	c.r = widen(8'(w[15:11]), 5);
	c.g = widen(8'(w[10:5]), 6);
	c.b = widen(8'(w[4:0]), 5);
	return c;
endfunction

function automatic rgb_t expand_555(input rtg_word_t w);
	rgb_t c;
	c.r = widen(8'(w[14:10]), 5);
	c.g = widen(8'(w[9:5]), 5);
	c.b = widen(8'(w[4:0]), 5);
	return c;
endfunction

////////////////////////////////////////
// Native video

// Lock onto a strobe and expect one every period clocks
task automatic pixel_period(input int period);
	wait_pixel(2 * period);
	for (int i = 1; i <= 4 * period; i++) begin
		next_cycle();
		check_bit("vga_pixel", vga_pixel, (i % period) == 0);
	end
endtask

task automatic native_passthrough();
	rgb_t held;
	rtg_ena = 1'b0;
	repeat (2) next_cycle();
	check_bit("mem_req", mem_req, 1'b0);  // No fetching while RTG is off
	for (int i = 0; i < 64; i++) begin
		held       = native_rgb;  // Already in the output register
		native_rgb = 24'($urandom);
		#1;
		check_rgb("vga_rgb", vga_rgb, held);  // Not yet through
		next_cycle();
		check_rgb("vga_rgb", vga_rgb, native_rgb);
	end
	pixel_period(8);
	scan_15khz = 1'b1;
	pixel_period(4);  // 15 kHz doubles the rate
	scan_15khz = 1'b0;
endtask

task automatic sync_and_osd();
	logic hs_prev;
	logic vs_prev;
	rgb_t got;
	rgb_t exp;
	rtg_ena = 1'b0;
	for (int i = 0; i < 64; i++) begin
		hs_prev = hsync;
		vs_prev = vsync;
		{hsync, vsync, csync, hsync_pol, vsync_pol, osd_window, osd_pixel} = 7'($urandom);
		native_rgb = 24'($urandom);
		#1;
		// Old syncs still out but new polarity applied
		check_bit("vga_hs", vga_hs, hs_prev ^ hsync_pol);
		check_bit("vga_vs", vga_vs, vs_prev ^ vsync_pol);
		next_cycle();
		check_bit("vga_hs", vga_hs, hsync ^ hsync_pol);
		check_bit("vga_vs", vga_vs, vsync ^ vsync_pol);
		check_bit("vga_cs", vga_cs, csync);
		if (osd_window) begin
			got = vga_rgb & 24'hc0c0c0;  // OSD owns the top two bits
			exp = osd_pixel ? 24'hc0c0c0 : 24'h000080;
		end else begin
			got = vga_rgb;
			exp = native_rgb;
		end
		check_rgb("vga_rgb", got, exp);
	end
	{hsync, vsync, csync, hsync_pol, vsync_pol, osd_window, osd_pixel} = 7'b0;
endtask

////////////////////////////////////////
// RTG frames

// Vblank and VB_LINES hsync lines with no pixel allowed
task automatic start_frame(input rtg_addr_t base);
	rtg_ena   = 1'b1;
	hblank    = 1'b0;
	hsync     = 1'b0;
	vblank    = 1'b1;
	base_addr = base;
	repeat (40) next_cycle();  // Long enough to drain a stale burst
	check_bit("mem_req", mem_req, 1'b0);  // Request held off in vblank
	check_addr("mem_addr", mem_addr, base);
	vblank = 1'b0;
	for (int l = 0; l < VB_LINES; l++) begin
		for (int c = 0; c < 16; c++) begin
			next_cycle();
			check_bit("vga_pixel", vga_pixel, 1'b0);  // Still extended blank
		end
		hsync = 1'b1;
		repeat (4) next_cycle();
		hsync = 1'b0;
	end
endtask

// n-th pixel shows word n of the frame
task automatic direct_pixels(input rtg_addr_t base, input int count);
	rtg_word_t w;
	rgb_t      exp;
	for (int n = 0; n < count; n++) begin
		wait_pixel(4 * (PIX_W + 1));
		w   = mem_word(base + rtg_addr_t'(n));
		exp = rtg_16bit ? expand_565(w) : expand_555(w);
		check_rgb("vga_rgb", vga_rgb, exp);
	end
endtask

task automatic rtg_16bit_frame();
	rtg_16bit = 1'b1;
	rtg_clut  = 1'b0;
	start_frame(BASE_A);
	direct_pixels(BASE_A, 48);  // More than a FIFO full
endtask

task automatic rtg_15bit_frame();
	rtg_16bit = 1'b0;
	rtg_clut  = 1'b0;
	start_frame(BASE_B);
	direct_pixels(BASE_B, 48);
endtask

task automatic clut_frame();
	rtg_word_t w;
	for (int i = 0; i < 256; i++) begin
		clut_ref[i] = 24'($urandom);
		clut_wr     = 1'b1;
		clut_wr_idx = clut_idx_t'(i);
		clut_wr_rgb = clut_ref[i];
		next_cycle();
	end
	clut_wr  = 1'b0;
	rtg_clut = 1'b1;
	start_frame(BASE_C);
	// Index strobe fires once before the first word arrives
	wait_pixel(4 * (PIX_W + 1));
	for (int n = 0; n < 32; n++) begin
		w = mem_word(BASE_C + rtg_addr_t'(n));
		wait_pixel(4 * (PIX_W + 1));
		check_rgb("vga_rgb", vga_rgb, clut_ref[w[15:8]]);  // High byte first
		wait_pixel(4 * (PIX_W + 1));
		check_rgb("vga_rgb", vga_rgb, clut_ref[w[7:0]]);
	end
	rtg_clut = 1'b0;
endtask

// Second vblank cuts the frame short with words still queued
task automatic frame_restart();
	rtg_16bit = 1'b1;
	rtg_clut  = 1'b0;
	start_frame(BASE_R);
	direct_pixels(BASE_R, 13);
	start_frame(BASE_R);
	direct_pixels(BASE_R, 40);
endtask

//--- tb/tb_rtg_video.sv
////////////////////////////////////////
// Testbench for the RTG video top level
// Serves the memory port and runs the directed tests
////////////////////////////////////////

`timescale 1ns/1ps

module tb_rtg_video
	import rtg_pkg::*;
();

	localparam int N_TESTS  = 6;  // Sizes the watchdog
	localparam int PIX_W    = 5;  // Six clocks per fetch
	localparam int VB_LINES = 3;  // Vblank extension lines

	localparam rtg_addr_t BASE_A = 25'h000_1230;
	localparam rtg_addr_t BASE_B = 25'h1ff_ffe8;  // Crosses the top of memory
	localparam rtg_addr_t BASE_C = 25'h0a5_5000;
	localparam rtg_addr_t BASE_R = 25'h123_4567;

	logic               CLK_114;
	logic               arst_n;
	logic               rtg_ena;
	logic               rtg_ext;
	logic               rtg_16bit;
	logic               rtg_clut;
	logic               scan_15khz;
	logic [PIXW_W-1:0]  pixel_width;
	logic [VBEND_W-1:0] vb_end;
	rtg_addr_t          base_addr;
	logic               clut_wr;
	clut_idx_t          clut_wr_idx;
	rgb_t               clut_wr_rgb;
	logic               hblank;
	logic               vblank;
	logic               hsync;
	logic               vsync;
	logic               csync;
	logic               hsync_pol;
	logic               vsync_pol;
	rgb_t               native_rgb;
	logic               osd_window;
	logic               osd_pixel;
	logic               mem_req;
	rtg_addr_t          mem_addr;
	logic               mem_fill;
	rtg_word_t          mem_data;
	logic [7:0]         vga_r;
	logic [7:0]         vga_g;
	logic [7:0]         vga_b;
	logic               vga_hs;
	logic               vga_vs;
	logic               vga_cs;
	logic               vga_pixel;
	rgb_t               vga_rgb;

	rgb_t clut_ref [256];  // Palette as written

	assign vga_rgb = {vga_r, vga_g, vga_b};

	rtg_video_top uut (
		.CLK_114(CLK_114), .arst_n(arst_n), .rtg_ena(rtg_ena), .rtg_ext(rtg_ext),
		.rtg_16bit(rtg_16bit), .rtg_clut(rtg_clut), .scan_15khz(scan_15khz),
		.pixel_width(pixel_width), .vb_end(vb_end), .base_addr(base_addr),
		.clut_wr(clut_wr), .clut_wr_idx(clut_wr_idx), .clut_wr_rgb(clut_wr_rgb),
		.hblank(hblank), .vblank(vblank), .hsync(hsync), .vsync(vsync),
		.csync(csync), .hsync_pol(hsync_pol), .vsync_pol(vsync_pol),
		.native_r(native_rgb.r), .native_g(native_rgb.g), .native_b(native_rgb.b),
		.osd_window(osd_window), .osd_pixel(osd_pixel),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_fill(mem_fill),
		.mem_data(mem_data),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs),
		.vga_vs(vga_vs), .vga_cs(vga_cs), .vga_pixel(vga_pixel)
	);

	initial begin
		CLK_114 = 1'b0;
		forever #2 CLK_114 = ~CLK_114;  // 250 MHz
	end

	////////////////////////////////////////
	// Shared helpers

	// Memory contents, low 16 bits of addr * 9e37
	function automatic rtg_word_t mem_word(input rtg_addr_t addr);
		logic [31:0] prod;
		prod = 32'(addr) * 32'h9e37;
		return prod[15:0];
	endfunction

	// Just past the next rising edge, where inputs change
	task automatic next_cycle();
		@(posedge CLK_114);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	// Stops on the first cycle with vga_pixel high
	task automatic wait_pixel(input int limit);
		int n;
		n = 0;
		next_cycle();
		while (!vga_pixel) begin
			if (n >= limit) begin
				abort_run("vga_pixel strobe did not arrive in time");
			end else begin
				n++;
				next_cycle();
			end
		end
	endtask

	`include "rtg_tb_tasks.svh"

	initial begin
		repeat (N_TESTS * 20000) @(posedge CLK_114);
		abort_run("watchdog expired, the tests did not finish");
	end

	////////////////////////////////////////
	// Memory model

	// Eight fills per request with 0 to 2 idle clocks between them
	initial begin
		rtg_addr_t   burst_addr;
		int unsigned gap;
		mem_fill = 1'b0;
		mem_data = '0;
		forever begin
			next_cycle();
			if (arst_n && mem_req) begin
				burst_addr = mem_addr;  // Held while mem_req is high
				for (int i = 0; i < BURST_WORDS; i++) begin
					gap = $urandom % 3;
					repeat (gap) next_cycle();
					mem_fill = 1'b1;
					mem_data = mem_word(burst_addr + rtg_addr_t'(i));
					next_cycle();
					mem_fill = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(32'h5bb));
		arst_n      = 1'b0;
		rtg_ena     = 1'b0;
		rtg_ext     = 1'b0;
		rtg_16bit   = 1'b0;
		rtg_clut    = 1'b0;
		scan_15khz  = 1'b0;
		pixel_width = PIXW_W'(PIX_W);
		vb_end      = VBEND_W'(VB_LINES);
		base_addr   = '0;
		clut_wr     = 1'b0;
		clut_wr_idx = '0;
		clut_wr_rgb = '0;
		hblank      = 1'b0;
		vblank      = 1'b1;
		hsync       = 1'b0;
		vsync       = 1'b0;
		csync       = 1'b0;
		hsync_pol   = 1'b0;
		vsync_pol   = 1'b0;
		native_rgb  = '0;
		osd_window  = 1'b0;
		osd_pixel   = 1'b0;
		repeat (16) @(posedge CLK_114);
		#1 arst_n = 1'b1;

		native_passthrough();
		sync_and_osd();
		rtg_16bit_frame();
		rtg_15bit_frame();
		clut_frame();
		frame_restart();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+tb
verilog/rtg_pkg.sv
verilog/rtg_beat_if.sv
verilog/rtg_pixel_timing.sv
verilog/rtg_stream_fetch.sv
verilog/rtg_video_mixer.sv
verilog/rtg_video_top.sv
tb/tb_rtg_video.sv

//--- run_sim.sh
#!/bin/sh
# Build the RTG video testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rtg_video -f build.f \
	&& ./obj_dir/Vtb_rtg_video 2>&1 | tee sim.log
[ -f sim.log ] || exit 1
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
